/* common/mem_front_macros.svh */
`ifndef MEM_FRONT_MACROS_SVH
`define MEM_FRONT_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read channel widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MF_ADDR_W 32
`define MF_DATA_W 32
`define MF_ID_W 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Start-up behaviour and read priorities
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MF_STRETCH_CYCLES 128 // Caches held in reset this long
`define MF_WARMUP_BURSTS 3 // Uncached bursts before caches open

`define MF_QOS_ICACHE 3
`define MF_QOS_DCACHE 12
`define MF_QOS_UNCACHED 3

`endif

/* common/axi_pkg.sv */
`include "mem_front_macros.svh"

package axi_pkg;

    typedef logic [`MF_ID_W-1:0] axi_id_t;
    typedef logic [`MF_ADDR_W-1:0] axi_addr_t;
    typedef logic [`MF_DATA_W-1:0] axi_data_t;

    // One read-address beat
    typedef struct packed {
        axi_id_t id;
        axi_addr_t addr;
        logic [3:0] len; // Beats minus one
        logic [2:0] size;
        logic [1:0] burst;
        logic valid;
    } axi_ar_t;

    // One read-data beat
    typedef struct packed {
        axi_id_t id;
        axi_data_t data;
        logic [1:0] resp;
        logic last; // Final beat of the burst
        logic valid;
    } axi_r_t;

endpackage

/* common/mem_front_pkg.sv */
package mem_front_pkg;

    localparam int NUM_PORTS = 3;

    // Requester ports, also sent as the external read id
    typedef enum logic [1:0] {
        PORT_ICACHE = 2'd0,
        PORT_DCACHE = 2'd1,
        PORT_UNCACHED = 2'd2
    } port_idx_t;

    typedef logic [NUM_PORTS-1:0] port_mask_t; // One bit per port

endpackage

/* verilog/startup_ctrl.sv */
`timescale 1ns/1ps

`include "mem_front_macros.svh"

module startup_ctrl (
    input logic Clk,
    input logic Myreset,
    input logic cache_off_i,
    input logic warm_burst_done_i,
    output logic cache_rst_o,
    output logic bypass_o
);

    localparam int STRETCH_W = $clog2(`MF_STRETCH_CYCLES);
    localparam int WARM_W = $clog2(`MF_WARMUP_BURSTS + 1);

    logic [STRETCH_W-1:0] stretch_cnt;
    logic cache_rst_q;
    logic [WARM_W-1:0] warm_cnt;
    logic warm_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache reset stretch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            cache_rst_q <= 1'b1;
            stretch_cnt <= '0;
        end else if (cache_rst_q) begin
            stretch_cnt <= stretch_cnt + 1'b1;
            if (stretch_cnt == STRETCH_W'(`MF_STRETCH_CYCLES - 1)) begin
                cache_rst_q <= 1'b0; // Last stretch cycle
            end
        end
    end

    assign cache_rst_o = cache_rst_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bypass warm-up
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign warm_done = (warm_cnt == WARM_W'(`MF_WARMUP_BURSTS));

    // Bursts finishing during the cache reset still count
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            warm_cnt <= '0;
        end else if (warm_burst_done_i && !warm_done) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

    assign bypass_o = !warm_done || cache_off_i; // Cache-off forces uncached only

    // Each finished burst counts once
    a_warm_pulse_single : assert property (
        @(posedge Clk) disable iff (Myreset)
        warm_burst_done_i |=> !warm_burst_done_i
    ) else $error("warm-up pulse held for more than one cycle");

endmodule

/* interconnect/read_arbiter.sv */
`timescale 1ns/1ps

`include "mem_front_macros.svh"

module read_arbiter (
    input logic Clk,
    input logic Myreset,
    input logic bypass_i,
    input axi_pkg::axi_ar_t port_ar_i [mem_front_pkg::NUM_PORTS],
    input mem_front_pkg::port_mask_t port_rready_i,
    input logic mem_arready_i,
    input axi_pkg::axi_r_t mem_r_i,
    output mem_front_pkg::port_mask_t port_arready_o,
    output axi_pkg::axi_r_t port_r_o [mem_front_pkg::NUM_PORTS],
    output axi_pkg::axi_ar_t mem_ar_o,
    output logic mem_rready_o,
    output logic warm_burst_done_o
);

    import axi_pkg::*;
    import mem_front_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR, // Grant locked, waiting for arready
        ST_BURST
    } state_t;

    localparam logic [3:0] QOS_W [NUM_PORTS] = '{
        4'(`MF_QOS_ICACHE),
        4'(`MF_QOS_DCACHE),
        4'(`MF_QOS_UNCACHED)
    };

    state_t state;
    port_idx_t owner_q;
    port_mask_t eligible;
    logic win_found;
    port_idx_t win_idx;
    logic [3:0] win_qos;
    port_idx_t sel_idx;
    logic ar_active;
    logic in_burst;
    logic r_fire;
    port_mask_t r_valid_mask;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Winner selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign eligible = bypass_i ? (port_mask_t'(1) << PORT_UNCACHED) : '1;

    // Strict compare keeps ties on the lower index
    always_comb begin
        win_found = 1'b0;
        win_idx = PORT_ICACHE;
        win_qos = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (eligible[i] && port_ar_i[i].valid && (!win_found || QOS_W[i] > win_qos)) begin
                win_found = 1'b1;
                win_idx = port_idx_t'(i);
                win_qos = QOS_W[i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sel_idx = (state == ST_IDLE) ? win_idx : owner_q;
    assign ar_active = (state == ST_IDLE && win_found) || state == ST_ADDR;

    always_comb begin
        mem_ar_o = port_ar_i[sel_idx];
        mem_ar_o.id = axi_id_t'(sel_idx); // Port number rides in the id
        mem_ar_o.valid = ar_active && port_ar_i[sel_idx].valid;
        port_arready_o = '0;
        if (ar_active) begin
            port_arready_o[sel_idx] = mem_arready_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign in_burst = (state == ST_BURST);
    assign mem_rready_o = in_burst && port_rready_i[owner_q];
    assign r_fire = mem_r_i.valid && mem_rready_o;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            r_valid_mask[i] = in_burst && owner_q == port_idx_t'(i) && mem_r_i.valid;
            port_r_o[i] = mem_r_i;
            port_r_o[i].valid = r_valid_mask[i];
        end
    end

    assign warm_burst_done_o = r_fire && mem_r_i.last && owner_q == PORT_UNCACHED;

    // One burst outstanding at a time
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            state <= ST_IDLE;
            owner_q <= PORT_ICACHE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (win_found) begin
                        owner_q <= win_idx; // Bypass only matters here
                        state <= mem_arready_i ? ST_BURST : ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (mem_ar_o.valid && mem_arready_i) begin
                        state <= ST_BURST;
                    end
                end
                ST_BURST: begin
                    if (r_fire && mem_r_i.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_arready_owner_only : assert property (
        @(posedge Clk) disable iff (Myreset)
        (|port_arready_o) |->
            mem_ar_o.valid && port_arready_o == (port_mask_t'(1) << mem_ar_o.id)
    ) else $error("arready reached a port that does not own the address channel");

    // Beats are routed only inside a burst, so a burst must open on an AR transfer
    a_burst_opens_on_ar : assert property (
        @(posedge Clk) disable iff (Myreset)
        $rose(in_burst) |-> $past(mem_ar_o.valid && mem_arready_i)
    ) else $error("read burst opened without an address transfer");

    a_rid_matches_owner : assert property (
        @(posedge Clk) disable iff (Myreset)
        in_burst && mem_r_i.valid |-> mem_r_i.id == axi_id_t'(owner_q)
    ) else $error("memory returned an id other than the burst owner");

endmodule

/* verilog/mem_front_top.sv */
`timescale 1ns/1ps

module mem_front_top (
    input logic Clk,
    input logic Myreset,
    input logic cache_off_i,
    output logic cache_rst_o,
    output logic bypass_o,

    // Requester side, indexed by port number
    input axi_pkg::axi_ar_t port_ar_i [mem_front_pkg::NUM_PORTS],
    input mem_front_pkg::port_mask_t port_rready_i,
    output mem_front_pkg::port_mask_t port_arready_o,
    output axi_pkg::axi_r_t port_r_o [mem_front_pkg::NUM_PORTS],

    // External memory side
    output axi_pkg::axi_ar_t mem_ar_o,
    input logic mem_arready_i,
    input axi_pkg::axi_r_t mem_r_i,
    output logic mem_rready_o
);

    logic warm_burst_done; // One pulse per finished uncached burst

    startup_ctrl i_startup_ctrl (
        .Clk (Clk),
        .Myreset (Myreset),
        .cache_off_i (cache_off_i),
        .warm_burst_done_i (warm_burst_done),
        .cache_rst_o (cache_rst_o),
        .bypass_o (bypass_o)
    );

    read_arbiter i_read_arbiter (
        .Clk (Clk),
        .Myreset (Myreset),
        .bypass_i (bypass_o),
        .port_ar_i (port_ar_i),
        .port_rready_i (port_rready_i),
        .mem_arready_i (mem_arready_i),
        .mem_r_i (mem_r_i),
        .port_arready_o (port_arready_o),
        .port_r_o (port_r_o),
        .mem_ar_o (mem_ar_o),
        .mem_rready_o (mem_rready_o),
        .warm_burst_done_o (warm_burst_done)
    );

endmodule

/* verif/mem_front_checker.sv */
`timescale 1ns/1ps

`include "mem_front_macros.svh"

module mem_front_checker (
    input logic Clk,
    input logic Myreset,
    input logic cache_off_i,
    input logic cache_rst_i,
    input logic bypass_i,
    input axi_pkg::axi_ar_t port_ar_i [mem_front_pkg::NUM_PORTS],
    input mem_front_pkg::port_mask_t port_rready_i,
    input mem_front_pkg::port_mask_t port_arready_i,
    input axi_pkg::axi_r_t port_r_i [mem_front_pkg::NUM_PORTS],
    input axi_pkg::axi_ar_t mem_ar_i,
    input logic mem_arready_i,
    input logic mem_rready_i,
    output int errors_o
);

    import axi_pkg::*;
    import mem_front_pkg::*;

    int err_cnt = 0;
    int stretch_cnt;
    logic stretch_checked;
    int unc_bursts;
    logic busy; // Burst between AR transfer and last beat
    logic ar_wait; // Grant shown, AR not yet accepted
    axi_addr_t req_addr [NUM_PORTS];
    int req_len [NUM_PORTS];
    int beat [NUM_PORTS];
    logic burst_open [NUM_PORTS];

    assign errors_o = err_cnt;

    // Memory word for a given burst address and beat number
    function automatic axi_data_t ref_word(input axi_addr_t addr, input int beat_no);
        return (addr + (axi_addr_t'(beat_no) << 2)) ^ 32'hc3a5_0f1e;
    endfunction

    // Highest weight wins, ties stay on the lower index, -1 when nobody asks
    function automatic int ref_pick(input port_mask_t valids, input logic bypass);
        int weight [NUM_PORTS];
        int pick;
        weight = '{`MF_QOS_ICACHE, `MF_QOS_DCACHE, `MF_QOS_UNCACHED};
        pick = -1;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (valids[i] && (!bypass || i == PORT_UNCACHED)) begin
                if (pick < 0 || weight[i] > weight[pick]) begin
                    pick = i;
                end
            end
        end
        return pick;
    endfunction

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare on every rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge Clk) begin
        int pick;
        logic exp_bypass;
        logic exp_rready;
        port_mask_t valids;
        if (Myreset) begin
            stretch_cnt = 0;
            stretch_checked = 1'b0;
            unc_bursts = 0;
            busy = 1'b0;
            ar_wait = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                burst_open[p] = 1'b0;
            end
        end else begin
            if (cache_rst_i) begin
                stretch_cnt++;
            end else if (!stretch_checked) begin
                stretch_checked = 1'b1;
                if (stretch_cnt != `MF_STRETCH_CYCLES) begin
                    report_mismatch($sformatf("cache reset held %0d cycles, expected %0d",
                        stretch_cnt, `MF_STRETCH_CYCLES));
                end
            end
            exp_bypass = cache_off_i || unc_bursts < `MF_WARMUP_BURSTS;
            if (bypass_i !== exp_bypass) begin
                report_mismatch($sformatf("bypass %0b, expected %0b", bypass_i, exp_bypass));
            end
            if (bypass_i && mem_ar_i.valid && mem_ar_i.id != axi_id_t'(PORT_UNCACHED)) begin
                report_mismatch($sformatf("AR id %0d during bypass", mem_ar_i.id));
            end
            if (bypass_i && (port_arready_i[PORT_ICACHE] || port_arready_i[PORT_DCACHE])) begin
                report_mismatch("cache port saw arready during bypass");
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                valids[p] = port_ar_i[p].valid;
            end
            // Memory may only see rready from the port whose burst is open
            exp_rready = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                exp_rready = exp_rready || (burst_open[p] && port_rready_i[p]);
            end
            if (mem_rready_i !== exp_rready) begin
                report_mismatch($sformatf("memory rready %0b, expected %0b",
                    mem_rready_i, exp_rready));
            end
            if (!busy && !ar_wait) begin
                pick = ref_pick(valids, bypass_i);
                if (pick < 0 && mem_ar_i.valid) begin
                    report_mismatch("external AR valid with no eligible requester");
                end else if (pick >= 0 && (!mem_ar_i.valid || mem_ar_i.id != axi_id_t'(pick))) begin
                    report_mismatch($sformatf("AR id %0d valid %0b, expected port %0d",
                        mem_ar_i.id, mem_ar_i.valid, pick));
                end
            end
            if (mem_ar_i.valid && mem_arready_i) begin
                busy = 1'b1;
                ar_wait = 1'b0;
            end else if (mem_ar_i.valid) begin
                ar_wait = 1'b1;
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (port_ar_i[p].valid && port_arready_i[p]) begin
                    if (mem_ar_i.addr != port_ar_i[p].addr || mem_ar_i.len != port_ar_i[p].len) begin
                        report_mismatch($sformatf("port %0d request altered on the way out", p));
                    end
                    req_addr[p] = port_ar_i[p].addr;
                    req_len[p] = int'(port_ar_i[p].len);
                    beat[p] = 0;
                    burst_open[p] = 1'b1;
                end
                if (port_r_i[p].valid && port_rready_i[p]) begin
                    if (!burst_open[p]) begin
                        report_mismatch($sformatf("port %0d got a beat with no burst open", p));
                    end else begin
                        if (port_r_i[p].data !== ref_word(req_addr[p], beat[p])) begin
                            report_mismatch($sformatf("port %0d beat %0d data %h, expected %h",
                                p, beat[p], port_r_i[p].data, ref_word(req_addr[p], beat[p])));
                        end
                        if (port_r_i[p].last !== (beat[p] == req_len[p])) begin
                            report_mismatch($sformatf("port %0d beat %0d last %0b, len %0d",
                                p, beat[p], port_r_i[p].last, req_len[p]));
                        end
                        if (port_r_i[p].last) begin
                            burst_open[p] = 1'b0;
                            busy = 1'b0;
                            if (p == PORT_UNCACHED) begin
                                unc_bursts++;
                            end
                        end else begin
                            beat[p]++;
                        end
                    end
                end
            end
        end
    end

endmodule

/* verif/tb_mem_front.sv */
`timescale 1ns/1ps

`include "mem_front_macros.svh"

module tb_mem_front;

    import axi_pkg::*;
    import mem_front_pkg::*;

    localparam int WAIT_LIMIT = 2000; // Cycles

    logic Clk;
    logic Myreset;
    logic cache_off;
    logic cache_rst;
    logic bypass;
    axi_ar_t port_ar [NUM_PORTS];
    port_mask_t port_rready;
    port_mask_t port_arready;
    axi_r_t port_r [NUM_PORTS];
    axi_ar_t mem_ar;
    logic mem_arready;
    axi_r_t mem_r;
    logic mem_rready;
    int check_errors;
    int tb_errors = 0;

    mem_front_top i_mem_front_top (
        .Clk (Clk),
        .Myreset (Myreset),
        .cache_off_i (cache_off),
        .cache_rst_o (cache_rst),
        .bypass_o (bypass),
        .port_ar_i (port_ar),
        .port_rready_i (port_rready),
        .port_arready_o (port_arready),
        .port_r_o (port_r),
        .mem_ar_o (mem_ar),
        .mem_arready_i (mem_arready),
        .mem_r_i (mem_r),
        .mem_rready_o (mem_rready)
    );

    mem_front_checker i_mem_front_checker (
        .Clk (Clk),
        .Myreset (Myreset),
        .cache_off_i (cache_off),
        .cache_rst_i (cache_rst),
        .bypass_i (bypass),
        .port_ar_i (port_ar),
        .port_rready_i (port_rready),
        .port_arready_i (port_arready),
        .port_r_i (port_r),
        .mem_ar_i (mem_ar),
        .mem_arready_i (mem_arready),
        .mem_rready_i (mem_rready),
        .errors_o (check_errors)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Requesters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic issue_burst(input int p);
        int cnt;
        logic got;
        port_ar[p] = '0;
        port_ar[p].addr = $urandom & 32'hffff_fff0;
        port_ar[p].len = 4'($urandom_range(3));
        port_ar[p].size = 3'd2;
        port_ar[p].burst = 2'b01; // INCR
        port_ar[p].valid = 1'b1;
        cnt = 0;
        got = 1'b0;
        while (!got && cnt < WAIT_LIMIT) begin
            @(posedge Clk);
            got = port_arready[p];
            cnt++;
        end
        #10;
        port_ar[p].valid = 1'b0;
        if (!got) begin
            tb_errors++;
            $display("Timeout: port %0d never had its read address accepted", p);
            return;
        end
        cnt = 0;
        got = 1'b0;
        while (!got && cnt < WAIT_LIMIT) begin
            port_rready[p] = ($urandom_range(2) != 0); // Random rready gaps
            @(posedge Clk);
            got = port_r[p].valid && port_rready[p] && port_r[p].last;
            cnt++;
            #10;
        end
        port_rready[p] = 1'b0;
        if (!got) begin
            tb_errors++;
            $display("Timeout: port %0d never received the last beat of its burst", p);
        end
    endtask

    task automatic run_port(input int p, input int n);
        for (int i = 0; i < n; i++) begin
            issue_burst(p);
            repeat ($urandom_range(2)) begin
                @(posedge Clk);
                #10;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory slave, one burst at a time
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        axi_ar_t cap;
        int beat;
        logic busy;
        logic r_pend;
        mem_arready = 1'b0;
        mem_r = '0;
        cap = '0;
        beat = 0;
        busy = 1'b0;
        r_pend = 1'b0;
        forever begin
            @(posedge Clk);
            if (Myreset) begin
                busy = 1'b0;
                r_pend = 1'b0;
            end else if (busy) begin
                if (r_pend && mem_rready) begin
                    r_pend = 1'b0;
                    busy = (beat != int'(cap.len));
                    beat++;
                end
            end else if (mem_ar.valid && mem_arready) begin
                cap = mem_ar;
                beat = 0;
                busy = 1'b1;
            end
            #10;
            mem_arready = !Myreset && !busy && ($urandom_range(2) != 0);
            if (busy && !r_pend) begin
                r_pend = ($urandom_range(3) != 0); // Random rvalid gaps
            end
            mem_r = '0;
            if (r_pend) begin
                mem_r.id = cap.id;
                mem_r.data = i_mem_front_checker.ref_word(cap.addr, beat);
                mem_r.last = (beat == int'(cap.len));
                mem_r.valid = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int cnt;
        void'($urandom(16512));
        Myreset = 1'b1;
        cache_off = 1'b0;
        port_rready = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_ar[p] = '0;
        end
        repeat (4) @(posedge Clk);
        #10;
        Myreset = 1'b0;
        fork // Cache ports wait out the warm-up
            run_port(PORT_ICACHE, 6);
            run_port(PORT_DCACHE, 6);
            run_port(PORT_UNCACHED, 8);
        join
        cnt = 0;
        while (cache_rst && cnt < WAIT_LIMIT) begin
            @(posedge Clk);
            #10;
            cnt++;
        end
        if (cache_rst) begin
            tb_errors++;
            $display("Timeout: cache reset was never released");
        end
        if (bypass) begin
            tb_errors++;
            $display("Fail %0t: bypass still high after the warm-up bursts", $time);
        end
        cache_off = 1'b1;
        run_port(PORT_UNCACHED, 3);
        cache_off = 1'b0;
        fork
            run_port(PORT_ICACHE, 3);
            run_port(PORT_DCACHE, 3);
            run_port(PORT_UNCACHED, 3);
        join
        repeat (3) @(posedge Clk);
        $display("Errors: checker %0d, testbench %0d", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/axi_pkg.sv
common/mem_front_pkg.sv
verilog/startup_ctrl.sv
interconnect/read_arbiter.sv
verilog/mem_front_top.sv
verif/mem_front_checker.sv
verif/tb_mem_front.sv
